// ==== Makefile ====
SOURCES := $(wildcard src/*.sv) $(wildcard tests/*.sv)

run: obj_dir/Vrunner_tb
	./obj_dir/Vrunner_tb

obj_dir/Vrunner_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module runner_tb -f filelist.f

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== filelist.f ====
src/runner_pkg.sv
src/pace_config.sv
src/frame_sequencer.sv
src/control_edge.sv
src/frame_rate_sampler.sv
src/runner_top.sv
tests/runner_sva.sv
tests/runner_tb.sv

// ==== src/control_edge.sv ====
module control_edge (
    input  logic                  clk_render,
    input  logic                  rst_n,
    input  logic                  new_frame,
    input  runner_pkg::controls_t buttons,   // clean levels
    output runner_pkg::controls_t controls   // rising edges, held for one frame
);

    runner_pkg::controls_t buttons_prev;  // levels at the previous frame boundary

    // compare against the last frame's levels rather than the last cycle's
    // so a press counts once no matter how long it is held
    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            buttons_prev <= '0;
            controls     <= '0;
        end else if (new_frame) begin
            buttons_prev <= buttons;
            controls     <= runner_pkg::controls_t'(buttons & ~buttons_prev);
        end
    end

endmodule

// ==== src/frame_rate_sampler.sv ====
module frame_rate_sampler (
    input  logic                  clk_render,
    input  logic                  rst_n,
    input  logic                  new_frame,
    input  runner_pkg::obstacle_t obstacle,
    input  logic                  obstacle_valid,
    output logic [15:0]           frame_rate,        // frames in the last sample period
    output runner_pkg::obstacle_t sampled_obstacle
);

    logic [runner_pkg::sample_cnt_w-1:0] period_cnt;  // free running
    logic [15:0]                         frame_cnt;   // frames in the current period
    runner_pkg::obstacle_t               last_obstacle;
    logic                                boundary;

    assign boundary = (period_cnt == '0);

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else if (period_cnt == runner_pkg::sample_cnt_w'(runner_pkg::sample_period - 1)) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // a pulse or obstacle landing on the boundary cycle still counts
    // toward the period that closes there
    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt        <= '0;
            last_obstacle    <= '0;
            frame_rate       <= '0;
            sampled_obstacle <= '0;
        end else begin
            if (obstacle_valid) begin
                last_obstacle <= obstacle;
            end

            if (boundary) begin
                frame_rate       <= frame_cnt + {15'd0, new_frame};
                frame_cnt        <= '0;
                sampled_obstacle <= obstacle_valid ? obstacle : last_obstacle;
            end else if (new_frame) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
        end
    end

endmodule

// ==== src/frame_sequencer.sv ====
module frame_sequencer (
    input  logic       clk_render,
    input  logic       rst_n,
    input  logic       projector_done,  // level, projection finished for this frame
    input  logic       render_done,     // level, renderer drained
    input  logic [7:0] lag_limit,       // latched per frame by pace_config
    output logic       new_frame,       // one cycle pulse, marks a frame boundary
    output logic       render_active
);

    runner_pkg::frame_state_e state;
    logic [6:0]  wait_counter;   // cycles spent in st_wait
    logic [31:0] lag_counter;    // cycles since the frame started
    logic [31:0] min_frame_len;  // lag switches scaled to cycles
    logic        lag_met;

    assign min_frame_len = {24'd0, lag_limit} << runner_pkg::lag_shift;
    assign lag_met       = (lag_counter >= min_frame_len);  // only ever stretches a frame

    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            state         <= runner_pkg::st_rst;
            new_frame     <= 1'b0;
            render_active <= 1'b0;
            wait_counter  <= '0;
            lag_counter   <= '0;
        end else begin
            new_frame <= 1'b0;  // strobe by default

            case (state)
                runner_pkg::st_rst: begin
                    render_active <= 1'b0;
                    lag_counter   <= '0;
                    state         <= runner_pkg::st_start;
                end

                runner_pkg::st_start: begin
                    render_active <= 1'b0;
                    new_frame     <= 1'b1;  // seen high while already in st_wait
                    wait_counter  <= '0;
                    lag_counter   <= lag_counter + 32'd1;
                    state         <= runner_pkg::st_wait;
                end

                runner_pkg::st_wait: begin
                    // fixed pause so stale done levels from the last frame drop
                    lag_counter  <= lag_counter + 32'd1;
                    wait_counter <= wait_counter + 7'd1;
                    if (wait_counter == 7'(runner_pkg::wait_cycles - 1)) begin
                        state <= runner_pkg::st_generation;
                    end
                end

                runner_pkg::st_generation: begin
                    lag_counter <= lag_counter + 32'd1;
                    if (projector_done) begin
                        state         <= runner_pkg::st_rendering;
                        render_active <= 1'b1;
                    end
                end

                runner_pkg::st_rendering: begin
                    // hold here until the renderer is done and the frame is long enough
                    if (render_done && lag_met) begin
                        state         <= runner_pkg::st_start;
                        render_active <= 1'b0;
                        lag_counter   <= '0;
                    end else begin
                        lag_counter <= lag_counter + 32'd1;
                    end
                end

                default: begin
                    state <= runner_pkg::st_rst;  // recover from an illegal encoding
                end
            endcase
        end
    end

endmodule

// ==== src/pace_config.sv ====
module pace_config (
    input  logic               clk_render,
    input  logic               rst_n,
    input  logic               new_frame,     // one cycle strobe from the sequencer
    input  runner_pkg::speed_t speed,         // raw switch level
    input  logic [7:0]         lag_limit_sw,  // raw switch level
    output logic [7:0]         lag_limit,     // held for the whole frame
    output runner_pkg::pace_t  pace
);

    runner_pkg::speed_t speed_q;  // speed in force for this frame

    // switches are only looked at on frame boundaries
    // so game physics never change partway through a frame
    always_ff @(posedge clk_render or negedge rst_n) begin
        if (!rst_n) begin
            speed_q   <= '0;
            lag_limit <= '0;
        end else if (new_frame) begin
            speed_q   <= speed;
            lag_limit <= lag_limit_sw;
        end
    end

    // highest set bit picks the entry
    // speed 0 falls through to the slowest setting
    always_comb begin
        if (speed_q[3]) begin
            pace = runner_pkg::pace_speed8;
        end else if (speed_q[2]) begin
            pace = runner_pkg::pace_speed4;  // covers 4..7
        end else if (speed_q[1]) begin
            pace = runner_pkg::pace_speed2;  // 2 and 3
        end else begin
            pace = runner_pkg::pace_speed1;  // 0 and 1
        end
    end

endmodule

// ==== src/runner_pkg.sv ====
package runner_pkg;

    // frame pacing constants
    localparam int unsigned wait_cycles   = 100;   // settle time after each new frame
    localparam int unsigned lag_shift     = 8;     // lag switches scaled up by this shift
    localparam int unsigned sample_period = 2000;  // clk_render cycles per frame-rate sample
    localparam int unsigned sample_cnt_w  = $clog2(sample_period);

    // top level sequencer states
    typedef enum logic [2:0] {
        st_rst,
        st_start,
        st_wait,        // lets done levels from the last frame clear out
        st_generation,  // obstacles and projection running
        st_rendering    // triangles going to the renderer
    } frame_state_e;

    typedef logic [3:0] speed_t;  // switch value, one-hot in normal use

    // one obstacle as the generator emits it
    typedef struct packed {
        logic [2:0]  kind;
        logic [1:0]  lane;
        logic [10:0] depth;  // far end of the obstacle, unsigned
    } obstacle_t;

    // button order matches the board, msb first
    typedef struct packed {
        logic left;
        logic duck;
        logic jump;
        logic right;
    } controls_t;

    // physics settings handed to game logic
    typedef struct packed {
        logic [5:0] gravity;        // vertical velocity loss per frame, in 128ths
        logic [7:0] duck_limit;     // frames a duck lasts
        logic [9:0] vertical_jump;  // jump velocity, in 128ths
    } pace_t;

    // speed to physics table
    localparam pace_t pace_speed1 = '{
        gravity:       6'd1,
        duck_limit:    8'd128,
        vertical_jump: 10'd108
    };
    localparam pace_t pace_speed2 = '{
        gravity:       6'd4,
        duck_limit:    8'd64,
        vertical_jump: 10'd220
    };
    localparam pace_t pace_speed4 = '{
        gravity:       6'd15,
        duck_limit:    8'd32,
        vertical_jump: 10'd470
    };
    localparam pace_t pace_speed8 = '{
        gravity:       6'd60,
        duck_limit:    8'd16,
        vertical_jump: 10'd360  // lower than speed 4 so jumps stay short at top speed
    };

endpackage

// ==== src/runner_top.sv ====
module runner_top (
    input  logic                  clk_render,
    input  logic                  rst_n,
    input  runner_pkg::speed_t    speed,           // switch level
    input  logic [7:0]            lag_limit,       // switch level
    input  runner_pkg::controls_t buttons,         // clean button levels
    input  logic                  projector_done,
    input  logic                  render_done,
    input  runner_pkg::obstacle_t obstacle,
    input  logic                  obstacle_valid,
    output logic                  new_frame,
    output logic                  render_active,
    output runner_pkg::controls_t controls,
    output runner_pkg::pace_t     pace,
    output logic [15:0]           frame_rate,
    output runner_pkg::obstacle_t sampled_obstacle
);

    logic [7:0] lag_limit_frame;  // lag switches as latched for this frame

    pace_config i_pace_config (
        .clk_render   (clk_render),
        .rst_n        (rst_n),
        .new_frame    (new_frame),
        .speed        (speed),
        .lag_limit_sw (lag_limit),
        .lag_limit    (lag_limit_frame),
        .pace         (pace)
    );

    frame_sequencer i_frame_sequencer (
        .clk_render     (clk_render),
        .rst_n          (rst_n),
        .projector_done (projector_done),
        .render_done    (render_done),
        .lag_limit      (lag_limit_frame),
        .new_frame      (new_frame),
        .render_active  (render_active)
    );

    control_edge i_control_edge (
        .clk_render (clk_render),
        .rst_n      (rst_n),
        .new_frame  (new_frame),
        .buttons    (buttons),
        .controls   (controls)
    );

    frame_rate_sampler i_frame_rate_sampler (
        .clk_render       (clk_render),
        .rst_n            (rst_n),
        .new_frame        (new_frame),
        .obstacle         (obstacle),
        .obstacle_valid   (obstacle_valid),
        .frame_rate       (frame_rate),
        .sampled_obstacle (sampled_obstacle)
    );

endmodule

// ==== tests/runner_sva.sv ====
module runner_sva (
    input logic                  clk_render,
    input logic                  rst_n,
    input logic                  new_frame,
    input logic                  render_active,
    input runner_pkg::controls_t controls
);
    timeunit 1ns;
    timeprecision 100ps;

    // frame boundary is a single cycle strobe
    a_new_frame_pulse: assert property (
        @(posedge clk_render) disable iff (!rst_n)
        new_frame |=> !new_frame
    ) else $error("new_frame stayed high for two cycles");

    // the pulse comes from st_start, never while rendering
    a_frame_vs_render: assert property (
        @(posedge clk_render) disable iff (!rst_n)
        !(new_frame && render_active)
    ) else $error("new_frame and render_active high together");

    // edges are only taken on a frame boundary
    a_controls_held: assert property (
        @(posedge clk_render) disable iff (!rst_n)
        (controls != $past(controls)) |-> $past(new_frame)
    ) else $error("controls changed outside a frame boundary");

endmodule

// ==== tests/runner_tb.sv ====
module runner_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // one frame of stimulus and what the DUT should answer with
    typedef struct packed {
        runner_pkg::speed_t    speed;
        logic [7:0]            lag_limit;
        runner_pkg::controls_t buttons;
        logic [11:0]           proj_at;       // cycles after new_frame until projector_done
        logic [11:0]           render_after;  // cycles after render_active rises until render_done
        runner_pkg::controls_t exp_controls;
        runner_pkg::pace_t     exp_pace;
    } frame_case_t;

    localparam int n_cases = 10;

    logic                  clk_render;
    logic                  rst_n;
    runner_pkg::speed_t    speed;
    logic [7:0]            lag_limit;
    runner_pkg::controls_t buttons;
    logic                  projector_done;
    logic                  render_done;
    runner_pkg::obstacle_t obstacle;
    logic                  obstacle_valid;
    logic                  new_frame;
    logic                  render_active;
    runner_pkg::controls_t controls;
    runner_pkg::pace_t     pace;
    logic [15:0]           frame_rate;
    runner_pkg::obstacle_t sampled_obstacle;

    frame_case_t cases [n_cases];
    int          seed = 44;
    int          cycles;         // clock cycles since time zero
    int          cycle_limit;
    int          next_frame_at;  // cycle the next new_frame is due, -1 when unknown
    int          samples_seen;

    // sampler model state, kept by the negedge monitor
    int                    since_release;
    logic [15:0]           frames_in_period;
    runner_pkg::obstacle_t last_driven;
    logic                  sample_due;
    logic [15:0]           exp_rate;
    runner_pkg::obstacle_t exp_obstacle;

    runner_top i_dut (.*);

    bind runner_top runner_sva i_runner_sva (.*);

    initial begin
        clk_render = 1'b0;
        forever #20 clk_render = ~clk_render;  // 40 ns period
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_controls(input runner_pkg::controls_t got,
                                  input runner_pkg::controls_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: controls expected %b got %b", $time, exp, got));
        end
    endtask

    task automatic check_pace(input runner_pkg::pace_t got, input runner_pkg::pace_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: pace expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_obstacle(input runner_pkg::obstacle_t got,
                                  input runner_pkg::obstacle_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: sampled_obstacle expected %h got %h",
                               $time, exp, got));
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: frame_rate expected %0d got %0d",
                               $time, exp, got));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got));
        end
    endtask

    // one clock, inputs change 5 ns after the edge
    task automatic tick();
        int rnd;
        @(posedge clk_render);
        #5;
        cycles++;
        if (cycles > cycle_limit) begin
            fail_now($sformatf("timeout after %0d cycles, the frame sequence stalled", cycles));
        end
        rnd            = $random(seed);
        obstacle_valid = (rnd[1:0] == 2'b00);  // about one cycle in four
        obstacle       = rnd[31:16];
    endtask

    // first cycle with render_active high, counted from the new_frame cycle
    function automatic int rise_cycle(input frame_case_t c);
        int proj;
        proj = int'(c.proj_at);
        if (proj < int'(runner_pkg::wait_cycles)) begin
            proj = int'(runner_pkg::wait_cycles);  // done level ignored until generation
        end
        return proj + 1;
    endfunction

    // last cycle spent rendering, counted from the new_frame cycle
    function automatic int frame_end(input frame_case_t c);
        int done_at;
        int lag_min;
        done_at = rise_cycle(c) + int'(c.render_after);
        lag_min = (int'(c.lag_limit) << runner_pkg::lag_shift) - 1;  // st_start is cycle -1
        return (done_at > lag_min) ? done_at : lag_min;
    endfunction

    task automatic load_cases();
        // speed, lag, buttons, proj_at, render_after, expected controls, expected pace
        cases[0] = '{4'd1,  8'd0, 4'b0000, 12'd3,   12'd5,   4'b0000, runner_pkg::pace_speed1};
        cases[1] = '{4'd2,  8'd0, 4'b0010, 12'd110, 12'd0,   4'b0010, runner_pkg::pace_speed2};
        cases[2] = '{4'd4,  8'd1, 4'b0010, 12'd100, 12'd2,   4'b0000, runner_pkg::pace_speed4};
        cases[3] = '{4'd8,  8'd0, 4'b0000, 12'd120, 12'd10,  4'b0000, runner_pkg::pace_speed8};
        cases[4] = '{4'd0,  8'd0, 4'b0010, 12'd105, 12'd1,   4'b0010, runner_pkg::pace_speed1};
        cases[5] = '{4'd3,  8'd2, 4'b1001, 12'd101, 12'd0,   4'b1001, runner_pkg::pace_speed2};
        cases[6] = '{4'd12, 8'd0, 4'b1101, 12'd100, 12'd4,   4'b0100, runner_pkg::pace_speed8};
        cases[7] = '{4'd5,  8'd1, 4'b0000, 12'd0,   12'd300, 4'b0000, runner_pkg::pace_speed4};
        cases[8] = '{4'd6,  8'd4, 4'b0001, 12'd130, 12'd0,   4'b0001, runner_pkg::pace_speed4};
        cases[9] = '{4'd9,  8'd8, 4'b0011, 12'd100, 12'd7,   4'b0010, runner_pkg::pace_speed8};
    endtask

    // drives one table entry through a whole frame
    task automatic run_frame(input int idx);
        frame_case_t c;
        int          rise;
        int          done_at;
        int          last_render;
        int          k;
        c           = cases[idx];
        rise        = rise_cycle(c);
        done_at     = rise + int'(c.render_after);
        last_render = frame_end(c);
        speed       = c.speed;      // latched at the coming new_frame
        lag_limit   = c.lag_limit;
        buttons     = c.buttons;
        while (new_frame !== 1'b1) begin
            tick();
        end
        if (next_frame_at >= 0) begin
            check_cycle("new_frame cycle", cycles, next_frame_at);
        end
        check_level("render_active", render_active, 1'b0);
        projector_done = (c.proj_at == 12'd0);
        for (k = 1; k <= last_render + 1; k++) begin
            tick();
            if (k == 1) begin
                check_pace(pace, c.exp_pace);
                check_controls(controls, c.exp_controls);
            end
            check_level("render_active", render_active, (k >= rise) && (k <= last_render));
            check_level("new_frame", new_frame, 1'b0);
            projector_done = (k >= int'(c.proj_at));
            render_done    = (k >= done_at);
        end
        check_controls(controls, c.exp_controls);  // held for the whole frame
        projector_done = 1'b0;  // back in st_start, clear the done levels
        render_done    = 1'b0;
        next_frame_at  = cycles + 1;
    endtask

    // sampler model, looks at the DUT between edges
    always @(negedge clk_render) begin
        if (!rst_n) begin
            since_release    = 0;
            frames_in_period = '0;
            last_driven      = '0;
            sample_due       = 1'b0;
        end else begin
            if (sample_due) begin
                check_count(frame_rate, exp_rate);
                check_obstacle(sampled_obstacle, exp_obstacle);
                samples_seen++;
                sample_due = 1'b0;
            end
            if (since_release % int'(runner_pkg::sample_period) == 0) begin
                exp_rate         = frames_in_period + {15'd0, new_frame};  // closes the period
                exp_obstacle     = obstacle_valid ? obstacle : last_driven;
                frames_in_period = '0;
                sample_due       = 1'b1;
            end else if (new_frame) begin
                frames_in_period++;
            end
            if (obstacle_valid) begin
                last_driven = obstacle;
            end
            since_release++;
        end
    end

    initial begin
        int i;
        rst_n          = 1'b0;
        speed          = '0;
        lag_limit      = '0;
        buttons        = '0;
        projector_done = 1'b0;
        render_done    = 1'b0;
        obstacle       = '0;
        obstacle_valid = 1'b0;
        cycles         = 0;
        next_frame_at  = -1;
        samples_seen   = 0;
        load_cases();
        cycle_limit = 10 + 2 * int'(runner_pkg::sample_period);  // reset plus slack
        for (i = 0; i < n_cases; i++) begin
            cycle_limit += frame_end(cases[i]) + 2;
        end

        repeat (4) tick();
        check_level("new_frame", new_frame, 1'b0);
        check_level("render_active", render_active, 1'b0);
        check_controls(controls, '0);
        check_pace(pace, runner_pkg::pace_speed1);  // reset speed is zero
        check_count(frame_rate, '0);
        check_obstacle(sampled_obstacle, '0);
        rst_n = 1'b1;

        for (i = 0; i < n_cases; i++) begin
            run_frame(i);
        end
        while (samples_seen < 3) begin
            tick();  // boundaries at 0, 2000 and 4000 cycles after reset
        end
        $display("Test passed");
        $finish;
    end

endmodule
